// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_mem_shared -Mdir obj_dir

out=$(./obj_dir/Vtb_mem_shared)
echo "$out"

echo "$out" | grep -qx "STATUS: PASS"

// ==== sim.f ====
source/mem_pkg.sv
source/mem_block_ram.sv
source/mem_sequential_read_write.sv
source/mem_port_arbiter.sv
source/mem_shared_top.sv
testbench/tb_clock_gen.sv
testbench/mem_shared_sva.sv
testbench/tb_mem_shared.sv

// ==== source/mem_block_ram.sv ====
//####################################################################
// Inferred simple dual-port block RAM
// Read-first, with a read register and an enabled output register
//####################################################################

`timescale 1ns/1ps

module mem_block_ram
    import mem_pkg::*;
(
    input  logic                      clk,

    input  logic                      write_enable,
    input  logic [mem_addr_width-1:0] write_addr,
    input  logic [mem_data_width-1:0] write_data,

    input  logic                      read_enable,
    input  logic                      read_output_enable,
    input  logic [mem_addr_width-1:0] read_addr,
    output logic [mem_data_width-1:0] read_data
);

    logic [mem_data_width-1:0] mem [mem_depth];
    logic [mem_data_width-1:0] read_reg;

    // Same-address read and write in one cycle returns the old word
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
        if (read_enable) begin
            read_reg <= mem[read_addr];
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (read_output_enable) begin
            read_data <= read_reg;
        end
    end

endmodule

// ==== source/mem_pkg.sv ====
//####################################################################
// Shared memory subsystem definitions
// Widths, depth and the client encoding used by the port arbiter
//####################################################################

package mem_pkg;

    // Word address and data sizes
    localparam int mem_addr_width = 8;
    localparam int mem_data_width = 32;

    // Client-facing read ID width
    localparam int mem_id_width = 3;

    // Internal tag carries the client bit above the client ID
    localparam int mem_tag_width = mem_id_width + 1;

    localparam int mem_depth = 2 ** mem_addr_width;

    // Owner of a read tag and of the last read grant
    typedef enum logic {
        client_a = 1'b0,
        client_b = 1'b1
    } mem_client_t;

endpackage

// ==== source/mem_port_arbiter.sv ====
//####################################################################
// Two-client port arbiter for the shared memory
// Round-robin reads, client a priority writes, tag-based routing
//####################################################################

`timescale 1ns/1ps

module mem_port_arbiter
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // Client a
    input  logic                      rd_req_valid_a,
    output logic                      rd_req_ready_a,
    input  logic [mem_addr_width-1:0] rd_req_addr_a,
    input  logic [mem_id_width-1:0]   rd_req_id_a,
    output logic                      rd_rsp_valid_a,
    input  logic                      rd_rsp_ready_a,
    output logic [mem_data_width-1:0] rd_rsp_data_a,
    output logic [mem_id_width-1:0]   rd_rsp_id_a,
    input  logic                      wr_valid_a,
    output logic                      wr_ready_a,
    input  logic [mem_addr_width-1:0] wr_addr_a,
    input  logic [mem_data_width-1:0] wr_data_a,

    // Client b
    input  logic                      rd_req_valid_b,
    output logic                      rd_req_ready_b,
    input  logic [mem_addr_width-1:0] rd_req_addr_b,
    input  logic [mem_id_width-1:0]   rd_req_id_b,
    output logic                      rd_rsp_valid_b,
    input  logic                      rd_rsp_ready_b,
    output logic [mem_data_width-1:0] rd_rsp_data_b,
    output logic [mem_id_width-1:0]   rd_rsp_id_b,
    input  logic                      wr_valid_b,
    output logic                      wr_ready_b,
    input  logic [mem_addr_width-1:0] wr_addr_b,
    input  logic [mem_data_width-1:0] wr_data_b,

    // Engine side
    output logic                      rd_in_valid,
    input  logic                      rd_in_ready,
    output logic [mem_addr_width-1:0] rd_in_addr,
    output logic [mem_tag_width-1:0]  rd_in_tag,
    input  logic                      rd_out_valid,
    output logic                      rd_out_ready,
    input  logic [mem_data_width-1:0] rd_out_data,
    input  logic [mem_tag_width-1:0]  rd_out_tag,
    output logic                      wr_en,
    output logic [mem_addr_width-1:0] wr_addr,
    output logic [mem_data_width-1:0] wr_data
);

    mem_client_t last_grant;
    mem_client_t rd_grant;
    mem_client_t rsp_client;
    logic        a_wins;

    // Client a wins when alone or when b had the last grant
    always_comb begin
        a_wins   = rd_req_valid_a && (!rd_req_valid_b || last_grant == client_b);
        rd_grant = a_wins ? client_a : client_b;

        rd_in_valid = a_wins ? rd_req_valid_a : rd_req_valid_b;
        rd_in_addr  = a_wins ? rd_req_addr_a : rd_req_addr_b;
        rd_in_tag   = {rd_grant, (a_wins ? rd_req_id_a : rd_req_id_b)};

        // A client sees ready unless the other one is requesting and wins
        rd_req_ready_a = rd_in_ready && (a_wins || !rd_req_valid_b);
        rd_req_ready_b = rd_in_ready && !a_wins;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= client_b;
        end else if (rd_in_valid && rd_in_ready) begin
            last_grant <= rd_grant;
        end
    end

    // Response routing on the client bit of the tag
    always_comb begin
        rsp_client = mem_client_t'(rd_out_tag[mem_tag_width-1]);

        rd_rsp_valid_a = rd_out_valid && (rsp_client == client_a);
        rd_rsp_valid_b = rd_out_valid && (rsp_client == client_b);
        rd_rsp_data_a  = rd_out_data;
        rd_rsp_data_b  = rd_out_data;
        rd_rsp_id_a    = rd_out_tag[mem_id_width-1:0];
        rd_rsp_id_b    = rd_out_tag[mem_id_width-1:0];

        rd_out_ready = (rsp_client == client_a) ? rd_rsp_ready_a : rd_rsp_ready_b;
    end

    // Write selection with fixed priority to client a
    always_comb begin
        wr_ready_a = 1'b1;
        wr_ready_b = !wr_valid_a;
        wr_en      = wr_valid_a || wr_valid_b;
        wr_addr    = wr_valid_a ? wr_addr_a : wr_addr_b;
        wr_data    = wr_valid_a ? wr_data_a : wr_data_b;
    end

endmodule

// ==== source/mem_sequential_read_write.sv ====
//####################################################################
// Sequential read/write engine around the block RAM
// Two-stage valid/ready read pipeline with tags, always-ready writes
//####################################################################

`timescale 1ns/1ps

module mem_sequential_read_write
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      rd_in_valid,
    output logic                      rd_in_ready,
    input  logic [mem_addr_width-1:0] rd_in_addr,
    input  logic [mem_tag_width-1:0]  rd_in_tag,

    output logic                      rd_out_valid,
    input  logic                      rd_out_ready,
    output logic [mem_data_width-1:0] rd_out_data,
    output logic [mem_tag_width-1:0]  rd_out_tag,

    input  logic                      wr_en,
    input  logic [mem_addr_width-1:0] wr_addr,
    input  logic [mem_data_width-1:0] wr_data
);

    logic                     read_enable;
    logic                     read_output_enable;
    logic                     internal_ready;
    logic                     internal_valid;
    logic [mem_tag_width-1:0] internal_tag;

    // Output stage can take a new word when empty or draining
    always_comb begin
        internal_ready     = rd_out_ready || !rd_out_valid;
        rd_in_ready        = internal_ready || !internal_valid;
        read_enable        = rd_in_valid && rd_in_ready;
        read_output_enable = internal_valid && internal_ready;
    end

    mem_block_ram u_ram (
        .clk                (clk),
        .write_enable       (wr_en),
        .write_addr         (wr_addr),
        .write_data         (wr_data),
        .read_enable        (read_enable),
        .read_output_enable (read_output_enable),
        .read_addr          (rd_in_addr),
        .read_data          (rd_out_data)
    );

    // Valid flags follow the RAM read register and output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            internal_valid <= 1'b0;
            rd_out_valid   <= 1'b0;
        end else begin
            if (read_enable || internal_ready) begin
                internal_valid <= read_enable;
            end
            if (read_output_enable || rd_out_ready) begin
                rd_out_valid <= read_output_enable;
            end
        end
    end

    // Tags move in step with the data
    always_ff @(posedge clk) begin
        if (read_enable) begin
            internal_tag <= rd_in_tag;
        end
        if (read_output_enable) begin
            rd_out_tag <= internal_tag;
        end
    end

endmodule

// ==== source/mem_shared_top.sv ====
//####################################################################
// Shared memory subsystem top level
// Port arbiter in front of the sequential read/write engine
//####################################################################

`timescale 1ns/1ps

module mem_shared_top
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      rd_req_valid_a,
    output logic                      rd_req_ready_a,
    input  logic [mem_addr_width-1:0] rd_req_addr_a,
    input  logic [mem_id_width-1:0]   rd_req_id_a,
    output logic                      rd_rsp_valid_a,
    input  logic                      rd_rsp_ready_a,
    output logic [mem_data_width-1:0] rd_rsp_data_a,
    output logic [mem_id_width-1:0]   rd_rsp_id_a,
    input  logic                      wr_valid_a,
    output logic                      wr_ready_a,
    input  logic [mem_addr_width-1:0] wr_addr_a,
    input  logic [mem_data_width-1:0] wr_data_a,

    input  logic                      rd_req_valid_b,
    output logic                      rd_req_ready_b,
    input  logic [mem_addr_width-1:0] rd_req_addr_b,
    input  logic [mem_id_width-1:0]   rd_req_id_b,
    output logic                      rd_rsp_valid_b,
    input  logic                      rd_rsp_ready_b,
    output logic [mem_data_width-1:0] rd_rsp_data_b,
    output logic [mem_id_width-1:0]   rd_rsp_id_b,
    input  logic                      wr_valid_b,
    output logic                      wr_ready_b,
    input  logic [mem_addr_width-1:0] wr_addr_b,
    input  logic [mem_data_width-1:0] wr_data_b
);

    logic                      rd_in_valid;
    logic                      rd_in_ready;
    logic [mem_addr_width-1:0] rd_in_addr;
    logic [mem_tag_width-1:0]  rd_in_tag;
    logic                      rd_out_valid;
    logic                      rd_out_ready;
    logic [mem_data_width-1:0] rd_out_data;
    logic [mem_tag_width-1:0]  rd_out_tag;
    logic                      wr_en;
    logic [mem_addr_width-1:0] wr_addr;
    logic [mem_data_width-1:0] wr_data;

    mem_port_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_req_valid_a (rd_req_valid_a),
        .rd_req_ready_a (rd_req_ready_a),
        .rd_req_addr_a  (rd_req_addr_a),
        .rd_req_id_a    (rd_req_id_a),
        .rd_rsp_valid_a (rd_rsp_valid_a),
        .rd_rsp_ready_a (rd_rsp_ready_a),
        .rd_rsp_data_a  (rd_rsp_data_a),
        .rd_rsp_id_a    (rd_rsp_id_a),
        .wr_valid_a     (wr_valid_a),
        .wr_ready_a     (wr_ready_a),
        .wr_addr_a      (wr_addr_a),
        .wr_data_a      (wr_data_a),
        .rd_req_valid_b (rd_req_valid_b),
        .rd_req_ready_b (rd_req_ready_b),
        .rd_req_addr_b  (rd_req_addr_b),
        .rd_req_id_b    (rd_req_id_b),
        .rd_rsp_valid_b (rd_rsp_valid_b),
        .rd_rsp_ready_b (rd_rsp_ready_b),
        .rd_rsp_data_b  (rd_rsp_data_b),
        .rd_rsp_id_b    (rd_rsp_id_b),
        .wr_valid_b     (wr_valid_b),
        .wr_ready_b     (wr_ready_b),
        .wr_addr_b      (wr_addr_b),
        .wr_data_b      (wr_data_b),
        .rd_in_valid    (rd_in_valid),
        .rd_in_ready    (rd_in_ready),
        .rd_in_addr     (rd_in_addr),
        .rd_in_tag      (rd_in_tag),
        .rd_out_valid   (rd_out_valid),
        .rd_out_ready   (rd_out_ready),
        .rd_out_data    (rd_out_data),
        .rd_out_tag     (rd_out_tag),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    mem_sequential_read_write u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_in_valid  (rd_in_valid),
        .rd_in_ready  (rd_in_ready),
        .rd_in_addr   (rd_in_addr),
        .rd_in_tag    (rd_in_tag),
        .rd_out_valid (rd_out_valid),
        .rd_out_ready (rd_out_ready),
        .rd_out_data  (rd_out_data),
        .rd_out_tag   (rd_out_tag),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

endmodule

// ==== testbench/mem_shared_sva.sv ====
//####################################################################
// Concurrent checks on the read pipeline of the sequential engine
//####################################################################

`timescale 1ns/1ps

module mem_shared_sva
    import mem_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      rd_in_valid,
    input logic                      rd_in_ready,
    input logic                      rd_out_valid,
    input logic                      rd_out_ready,
    input logic [mem_data_width-1:0] rd_out_data,
    input logic [mem_tag_width-1:0]  rd_out_tag
);

    logic [1:0] in_flight;

    // Reads accepted and not yet handed back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 2'd0;
        end else begin
            in_flight <= in_flight + 2'(rd_in_valid && rd_in_ready)
                         - 2'(rd_out_valid && rd_out_ready);
        end
    end

    // Held response keeps data and tag
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_out_valid && !rd_out_ready |=>
            rd_out_valid && $stable(rd_out_data) && $stable(rd_out_tag))
        else $error("response changed while held under back-pressure");

    assert property (@(posedge clk) !rst_n |-> !rd_out_valid)
        else $error("rd_out_valid high during reset");

    // Empty pipeline always accepts
    assert property (@(posedge clk) disable iff (!rst_n)
        in_flight == 2'd0 |-> rd_in_ready)
        else $error("rd_in_ready low with both stages empty");

endmodule

bind mem_sequential_read_write mem_shared_sva u_sva (.*);

// ==== testbench/tb_clock_gen.sv ====
//####################################################################
// Testbench clock and reset generator
// 4 ns clock period with reset held low for 3 cycles
//####################################################################

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    always #2 clk = ~clk;

endmodule

// ==== testbench/tb_mem_shared.sv ====
//####################################################################
// Directed tests for the shared memory subsystem
// Memory model, response scoreboard, round-robin and stability checks
//####################################################################

`timescale 1ns/1ps

module tb_mem_shared
    import mem_pkg::*;
;

    localparam int total_txn = 400;

    logic clk;
    logic rst_n;
    logic rd_req_valid_a, rd_req_ready_a, rd_rsp_valid_a, rd_rsp_ready_a;
    logic rd_req_valid_b, rd_req_ready_b, rd_rsp_valid_b, rd_rsp_ready_b;
    logic wr_valid_a, wr_ready_a, wr_valid_b, wr_ready_b;
    logic [mem_addr_width-1:0] rd_req_addr_a, rd_req_addr_b, wr_addr_a, wr_addr_b;
    logic [mem_id_width-1:0]   rd_req_id_a, rd_req_id_b, rd_rsp_id_a, rd_rsp_id_b;
    logic [mem_data_width-1:0] rd_rsp_data_a, rd_rsp_data_b, wr_data_a, wr_data_b;

    logic [mem_data_width-1:0] model [mem_depth];
    mem_client_t               exp_client [$];
    logic [mem_id_width-1:0]   exp_id [$];
    logic [mem_data_width-1:0] exp_data [$];
    int                        exp_cycle [$];
    mem_client_t               last_client;
    logic [31:0]               lfsr;
    int                        errors;
    int                        cycle;
    logic                      check_latency;
    logic                      held_a, held_b;
    logic [mem_data_width-1:0] held_data_a, held_data_b;
    logic [mem_id_width-1:0]   held_id_a, held_id_b;
    logic                      traffic_done;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    mem_shared_top u_mem_shared_top (.*);

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic accept_read(input mem_client_t c, input logic [mem_addr_width-1:0] addr,
                               input logic [mem_id_width-1:0] id);
        if (rd_req_valid_a && rd_req_valid_b) begin
            assert (c != last_client) else begin
                errors++;
                $display("ERR rd grant: exp %h got %h", !last_client, c);
            end
        end
        exp_client.push_back(c);
        exp_id.push_back(id);
        exp_data.push_back(model[addr]);
        exp_cycle.push_back(cycle);
        last_client = c;
    endtask

    task automatic check_response(input mem_client_t c, input logic [mem_id_width-1:0] id,
                                  input logic [mem_data_width-1:0] data);
        int start;
        if (exp_client.size() == 0) begin
            errors++;
            $display("Response arrived with no outstanding read request");
            return;
        end
        start = exp_cycle.pop_front();
        assert (c == exp_client[0]) else begin
            errors++;
            $display("ERR rd_rsp client: exp %h got %h", exp_client[0], c);
        end
        assert (id == exp_id[0]) else begin
            errors++;
            $display("ERR rd_rsp_id: exp %h got %h", exp_id[0], id);
        end
        assert (data === exp_data[0]) else begin
            errors++;
            $display("ERR rd_rsp_data: exp %h got %h", exp_data[0], data);
        end
        assert (!check_latency || cycle - start == 2) else begin
            errors++;
            $display("ERR read latency: exp %h got %h", 2, cycle - start);
        end
        void'(exp_client.pop_front());
        void'(exp_id.pop_front());
        void'(exp_data.pop_front());
    endtask

    // Monitor on pre-edge values with a read-first model
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (held_a) begin
                assert (rd_rsp_valid_a && rd_rsp_data_a == held_data_a
                        && rd_rsp_id_a == held_id_a)
                else begin
                    errors++;
                    $display("ERR rd_rsp_a held (valid data id): exp 1 %h %h got %h %h %h",
                             held_data_a, held_id_a, rd_rsp_valid_a, rd_rsp_data_a,
                             rd_rsp_id_a);
                end
            end
            if (held_b) begin
                assert (rd_rsp_valid_b && rd_rsp_data_b == held_data_b
                        && rd_rsp_id_b == held_id_b)
                else begin
                    errors++;
                    $display("ERR rd_rsp_b held (valid data id): exp 1 %h %h got %h %h %h",
                             held_data_b, held_id_b, rd_rsp_valid_b, rd_rsp_data_b,
                             rd_rsp_id_b);
                end
            end
            // Client a has write priority
            if (wr_valid_a && wr_valid_b) begin
                assert (wr_ready_a && !wr_ready_b) else begin
                    errors++;
                    $display("ERR wr_ready_a/wr_ready_b: exp 1/0 got %h/%h",
                             wr_ready_a, wr_ready_b);
                end
            end
            held_a      = rd_rsp_valid_a && !rd_rsp_ready_a;
            held_b      = rd_rsp_valid_b && !rd_rsp_ready_b;
            held_data_a = rd_rsp_data_a;
            held_data_b = rd_rsp_data_b;
            held_id_a   = rd_rsp_id_a;
            held_id_b   = rd_rsp_id_b;
            if (rd_rsp_valid_a && rd_rsp_ready_a) begin
                check_response(client_a, rd_rsp_id_a, rd_rsp_data_a);
            end
            if (rd_rsp_valid_b && rd_rsp_ready_b) begin
                check_response(client_b, rd_rsp_id_b, rd_rsp_data_b);
            end
            if (rd_req_valid_a && rd_req_ready_a) begin
                accept_read(client_a, rd_req_addr_a, rd_req_id_a);
            end
            if (rd_req_valid_b && rd_req_ready_b) begin
                accept_read(client_b, rd_req_addr_b, rd_req_id_b);
            end
            if (wr_valid_a && wr_ready_a) model[wr_addr_a] = wr_data_a;
            if (wr_valid_b && wr_ready_b) model[wr_addr_b] = wr_data_b;
        end
    end

    // Request stays valid after transfer until the next call or a drop
    task automatic read_req(input mem_client_t c, input logic [mem_addr_width-1:0] addr,
                            input logic [mem_id_width-1:0] id);
        @(negedge clk);
        if (c == client_a) begin
            rd_req_valid_a = 1'b1;
            rd_req_addr_a  = addr;
            rd_req_id_a    = id;
            do @(posedge clk); while (!rd_req_ready_a);
        end else begin
            rd_req_valid_b = 1'b1;
            rd_req_addr_b  = addr;
            rd_req_id_b    = id;
            do @(posedge clk); while (!rd_req_ready_b);
        end
    endtask

    task automatic write_req(input mem_client_t c, input logic [mem_addr_width-1:0] addr,
                             input logic [mem_data_width-1:0] data);
        @(negedge clk);
        if (c == client_a) begin
            wr_valid_a = 1'b1;
            wr_addr_a  = addr;
            wr_data_a  = data;
            do @(posedge clk); while (!wr_ready_a);
        end else begin
            wr_valid_b = 1'b1;
            wr_addr_b  = addr;
            wr_data_b  = data;
            do @(posedge clk); while (!wr_ready_b);
        end
    endtask

    task automatic drop_read(input mem_client_t c);
        @(negedge clk);
        if (c == client_a) rd_req_valid_a = 1'b0;
        else rd_req_valid_b = 1'b0;
    endtask

    task automatic drop_write(input mem_client_t c);
        @(negedge clk);
        if (c == client_a) wr_valid_a = 1'b0;
        else wr_valid_b = 1'b0;
    endtask

    task automatic drain;
        do @(negedge clk); while (exp_client.size() != 0);
    endtask

    task automatic preload_memory;
        for (int i = 0; i < mem_depth; i++) begin
            write_req(client_a, i[7:0], {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd3});
        end
        drop_write(client_a);
    endtask

    task automatic write_then_read;
        logic [mem_addr_width-1:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = mem_addr_width'(take_bits(8));
            write_req(client_a, addrs[i], take_bits(32));
        end
        drop_write(client_a);
        check_latency = 1'b1;
        for (int i = 0; i < 8; i++) read_req(client_b, addrs[i], i[2:0]);
        drop_read(client_b);
        drain();
        check_latency = 1'b0;
    endtask

    task automatic both_read_every_cycle;
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    read_req(client_a, mem_addr_width'(take_bits(8)), i[2:0]);
                end
                drop_read(client_a);
            end
            begin
                for (int i = 0; i < 16; i++) begin
                    read_req(client_b, mem_addr_width'(take_bits(8)), ~i[2:0]);
                end
                drop_read(client_b);
            end
        join
        drain();
    endtask

    task automatic response_backpressure;
        @(negedge clk);
        rd_rsp_ready_a = 1'b0;
        fork
            begin
                for (int i = 0; i < 2; i++) read_req(client_a, 8'h10 + i[7:0], i[2:0]);
                drop_read(client_a);
            end
            begin
                for (int i = 0; i < 3; i++) read_req(client_b, 8'h20 + i[7:0], 3'd4 + i[2:0]);
                drop_read(client_b);
            end
            begin
                repeat (8) @(posedge clk);
                assert (rd_rsp_valid_a && rd_req_valid_b && !rd_req_ready_b) else begin
                    errors++;
                    $display("Client b was not stalled behind the held client a response");
                end
                @(negedge clk);
                rd_rsp_ready_a = 1'b1;
            end
        join
        drain();
    endtask

    task automatic same_address_writes;
        logic [mem_data_width-1:0] data_b;
        data_b = take_bits(32);
        fork
            begin
                write_req(client_a, 8'h42, take_bits(32));
                drop_write(client_a);
            end
            begin
                write_req(client_b, 8'h42, data_b);
                drop_write(client_b);
            end
            begin
                read_req(client_b, 8'h42, 3'd1);
                drop_read(client_b);
            end
        join
        read_req(client_a, 8'h42, 3'd2);
        drop_read(client_a);
        drain();
        assert (model[8'h42] == data_b) else begin
            errors++;
            $display("ERR model[42]: exp %h got %h", data_b, model[8'h42]);
        end
    endtask

    task automatic random_client(input mem_client_t c);
        for (int i = 0; i < 40; i++) begin
            if (take_bits(1)) begin
                read_req(c, {4'h3, 4'(take_bits(4))}, mem_id_width'(take_bits(3)));
                drop_read(c);
            end else begin
                write_req(c, {4'h3, 4'(take_bits(4))}, take_bits(32));
                drop_write(c);
            end
        end
    endtask

    task automatic random_traffic;
        traffic_done = 1'b0;
        fork
            while (!traffic_done) begin
                @(negedge clk);
                rd_rsp_ready_a = take_bits(2) != 0;
                rd_rsp_ready_b = take_bits(2) != 0;
            end
            begin
                fork
                    random_client(client_a);
                    random_client(client_b);
                join
                traffic_done = 1'b1;
            end
        join
        @(negedge clk);
        rd_rsp_ready_a = 1'b1;
        rd_rsp_ready_b = 1'b1;
        drain();
    endtask

    initial begin
        #(total_txn * 10 * 4 + 4000);
        $display("Watchdog timeout, the tests did not finish");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        lfsr           = 32'hdc0a;
        errors         = 0;
        cycle          = 0;
        check_latency  = 1'b0;
        held_a         = 1'b0;
        held_b         = 1'b0;
        last_client    = client_b;
        traffic_done   = 1'b0;
        rd_req_valid_a = 1'b0;
        rd_req_addr_a  = '0;
        rd_req_id_a    = '0;
        rd_rsp_ready_a = 1'b1;
        wr_valid_a     = 1'b0;
        wr_addr_a      = '0;
        wr_data_a      = '0;
        rd_req_valid_b = 1'b0;
        rd_req_addr_b  = '0;
        rd_req_id_b    = '0;
        rd_rsp_ready_b = 1'b1;
        wr_valid_b     = 1'b0;
        wr_addr_b      = '0;
        wr_data_b      = '0;
        @(posedge rst_n);
        @(negedge clk);
        assert (!rd_rsp_valid_a && !rd_rsp_valid_b && rd_req_ready_a && rd_req_ready_b
                && wr_ready_a && wr_ready_b)
        else begin
            errors++;
            $display("Outputs not in their reset state after reset");
        end
        preload_memory();
        write_then_read();
        both_read_every_cycle();
        response_backpressure();
        same_address_writes();
        random_traffic();
        repeat (4) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
